//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := arm_core_tb
FILELIST   := arm_core.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- arm_core.f
verilog/arm_pipe_pkg.sv
verilog/arm_fetch.sv
verilog/arm_decode.sv
verilog/arm_regfile.sv
verilog/arm_hazard_unit.sv
verilog/arm_execute.sv
verilog/arm_mem_wb.sv
verilog/arm_core.sv
sim/arm_core_assertions.sv
sim/arm_core_tb.sv

//--- sim/arm_core_assertions.sv
`default_nettype none

module arm_core_assertions (
  input wire logic                            CLOCK,
  input wire logic                            arst_n,
  input wire logic [arm_pipe_pkg::XLEN-1:0]   imem_addr,
  input wire arm_pipe_pkg::dmem_req_t         dmem_req,
  input wire arm_pipe_pkg::wb_t               wb
);
  timeunit 1ns;
  timeprecision 1ps;

  import arm_pipe_pkg::*;

  int fail_count = 0;

  a_rw_exclusive: assert property (@(posedge CLOCK) disable iff (!arst_n)
    !(dmem_req.read && dmem_req.write))
    else begin
      $error("data port read and write high together");
      fail_count++;
    end

  a_no_xzr_wb: assert property (@(posedge CLOCK) disable iff (!arst_n)
    wb.en |-> (wb.rd != ZERO_REG))
    else begin
      $error("write-back to X31");
      fail_count++;
    end

  a_fetch_aligned: assert property (@(posedge CLOCK) imem_addr[1:0] == 2'b00)
    else begin
      $error("fetch address not word aligned");
      fail_count++;
    end

  // Outputs stay quiet while reset is held
  a_quiet_in_reset: assert property (@(posedge CLOCK)
    !arst_n |-> !(wb.en || dmem_req.read || dmem_req.write))
    else begin
      $error("control output high during reset");
      fail_count++;
    end

endmodule

bind arm_core arm_core_assertions u_assertions (
  .CLOCK(CLOCK), .arst_n(arst_n), .imem_addr(imem_addr), .dmem_req(dmem_req), .wb(wb)
);

`default_nettype wire

//--- sim/arm_core_tb.sv
`default_nettype none

module arm_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import arm_pipe_pkg::*;

  localparam int              PROG_LEN = 200;
  localparam int              LAST     = PROG_LEN - 1;       // Index of the closing B
  localparam int              LIMIT    = 3 * PROG_LEN + 40;  // Cycles after reset
  localparam logic [XLEN-1:0] START_PC = 64'h0000_0000_0000_1000;
  localparam logic [XLEN-1:0] END_PC   = START_PC + XLEN'(LAST * 4);
  localparam int unsigned     SEED     = 32'ha0e247fc;

  typedef enum int {K_ADD, K_SUB, K_AND, K_ORR, K_LDUR, K_STUR, K_CBZ, K_B} kind_e;

  logic            CLOCK = 1'b0;
  logic            arst_n;
  logic [XLEN-1:0] imem_addr;
  logic [31:0]     imem_data;
  dmem_req_t       dmem_req;
  logic [XLEN-1:0] dmem_rdata;
  wb_t             wb;
  logic [XLEN-1:0] fetch_off;

  logic [31:0]      prog [0:PROG_LEN-1];
  kind_e            kind [0:PROG_LEN-1];
  logic [REG_W-1:0] dst  [0:PROG_LEN-1];  // rd, or rt for STUR and CBZ
  logic [REG_W-1:0] src1 [0:PROG_LEN-1];
  logic [REG_W-1:0] src2 [0:PROG_LEN-1];
  int               imm  [0:PROG_LEN-1];  // Branch offsets count instructions

  logic [XLEN-1:0] dmem_mem  [logic [XLEN-1:0]];
  logic [XLEN-1:0] model_mem [logic [XLEN-1:0]];
  wb_t             exp_wb[$];
  dmem_req_t       exp_store[$];

  int   cycles       = 0;
  int   wb_count     = 0;
  int   store_count  = 0;
  int   wb_errors    = 0;
  int   store_errors = 0;
  int   other_errors = 0;
  logic end_seen     = 1'b0;

  arm_core #(
    .RESET_PC(START_PC)
  ) u_dut (
    .CLOCK(CLOCK), .arst_n(arst_n), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .wb(wb)
  );

  always #10 CLOCK = ~CLOCK;  // 20 ns period

  always @(posedge CLOCK) begin
    if (arst_n) begin
      cycles <= cycles + 1;
    end
  end

  assign fetch_off = imem_addr - START_PC;

  always_comb begin
    if (fetch_off < XLEN'(PROG_LEN * 4)) begin
      imem_data = prog[fetch_off[9:2]];
    end else begin
      imem_data = 32'h0;                     // Past the program reads as NOP
    end
  end

  always_comb begin
    if (!dmem_req.read) begin
      dmem_rdata = '0;                       // Data only while a load is requested
    end else if (dmem_mem.exists(dmem_req.addr)) begin
      dmem_rdata = dmem_mem[dmem_req.addr];
    end else begin
      dmem_rdata = dmem_req.addr * 64'd5;    // Unwritten fill
    end
  end

  always @(posedge CLOCK) begin
    if (arst_n && dmem_req.write) begin
      dmem_mem[dmem_req.addr] = dmem_req.wdata;
    end
  end

  function automatic logic [REG_W-1:0] pick_reg();
    int roll;
    roll = int'($urandom % 10);
    if (roll < 6) begin
      return REG_W'($urandom % 6);           // Dense reuse of X0 to X5
    end else if (roll < 9) begin
      return REG_W'($urandom % 32);
    end
    return ZERO_REG;
  endfunction

  function automatic logic [31:0] encode(input kind_e k, input logic [REG_W-1:0] d,
                                         input logic [REG_W-1:0] n,
                                         input logic [REG_W-1:0] m, input int im);
    logic [31:0] v;
    v = 32'(im);
    case (k)
      K_ADD:   return {OP_ADD, m, 6'd0, n, d};
      K_SUB:   return {OP_SUB, m, 6'd0, n, d};
      K_AND:   return {OP_AND, m, 6'd0, n, d};
      K_ORR:   return {OP_ORR, m, 6'd0, n, d};
      K_LDUR:  return {OP_LDUR, v[8:0], 2'b00, n, d};
      K_STUR:  return {OP_STUR, v[8:0], 2'b00, n, d};
      K_CBZ:   return {OP_CBZ, v[18:0], d};
      default: return {OP_B, v[25:0]};
    endcase
  endfunction

  task automatic build_program();
    int i;
    int roll;
    int span;
    for (i = 0; i < LAST; i++) begin
      roll    = int'($urandom % 16);
      dst[i]  = pick_reg();
      src1[i] = pick_reg();
      src2[i] = pick_reg();
      imm[i]  = int'($urandom % 512) - 256;
      if (roll < 8) begin
        kind[i] = kind_e'(roll / 2);
      end else if (roll < 11) begin
        kind[i] = K_LDUR;
      end else if (roll < 13) begin
        kind[i] = K_STUR;
      end else begin
        kind[i] = (roll < 15) ? K_CBZ : K_B;
        span    = (LAST - i < 5) ? LAST - i : 5;
        imm[i]  = 1 + int'($urandom % span);  // Forward and never past the end
      end
      prog[i] = encode(kind[i], dst[i], src1[i], src2[i], imm[i]);
    end
    kind[LAST] = K_B;
    dst[LAST]  = '0;
    src1[LAST] = '0;
    src2[LAST] = '0;
    imm[LAST]  = 0;                            // Spins on itself
    prog[LAST] = encode(K_B, '0, '0, '0, 0);
  endtask

  // Architectural reference that runs the program in order
  task automatic run_model();
    logic [XLEN-1:0] x [0:31];
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] val;
    int              pc;
    int              steps;
    int              r;
    for (r = 0; r < 32; r++) begin
      x[r] = '0;
    end
    pc    = 0;
    steps = 0;
    while (pc != LAST && steps < PROG_LEN) begin
      addr = x[src1[pc]] + XLEN'(longint'(imm[pc]));
      val  = '0;
      case (kind[pc])
        K_ADD:  val = x[src1[pc]] + x[src2[pc]];
        K_SUB:  val = x[src1[pc]] - x[src2[pc]];
        K_AND:  val = x[src1[pc]] & x[src2[pc]];
        K_ORR:  val = x[src1[pc]] | x[src2[pc]];
        K_LDUR: val = model_mem.exists(addr) ? model_mem[addr] : addr * 64'd5;
        K_STUR: begin
          model_mem[addr] = x[dst[pc]];
          exp_store.push_back(dmem_req_t'{addr: addr, wdata: x[dst[pc]],
                                          read: 1'b0, write: 1'b1});
        end
        default: ;
      endcase
      if (kind[pc] <= K_LDUR && dst[pc] != ZERO_REG) begin
        x[dst[pc]] = val;
        exp_wb.push_back(wb_t'{en: 1'b1, rd: dst[pc], data: val});
      end
      if (kind[pc] == K_B || (kind[pc] == K_CBZ && x[dst[pc]] == '0)) begin
        pc += imm[pc];
      end else begin
        pc++;
      end
      steps++;
    end
  endtask

  task automatic check_wb(input wb_t act);
    wb_t   exp;
    string name;
    name = $sformatf("write-back %0d", wb_count);
    wb_count++;
    if (exp_wb.size() == 0) begin
      $display("ERROR: %s to X%0d came after the model had no write-backs left",
               name, act.rd);
      wb_errors++;
    end else begin
      exp = exp_wb.pop_front();
      if (act !== exp) begin
        $display("FAILED %s: expected X%0d=%h, actual X%0d=%h",
                 name, exp.rd, exp.data, act.rd, act.data);
        wb_errors++;
      end
    end
  endtask

  task automatic check_store(input dmem_req_t act);
    dmem_req_t exp;
    string     name;
    name = $sformatf("store %0d", store_count);
    store_count++;
    if (exp_store.size() == 0) begin
      $display("ERROR: %s to address %h was not produced by the model", name, act.addr);
      store_errors++;
    end else begin
      exp = exp_store.pop_front();
      if (act !== exp) begin
        $display("FAILED %s: expected [%h]=%h, actual [%h]=%h",
                 name, exp.addr, exp.wdata, act.addr, act.wdata);
        store_errors++;
      end
    end
  endtask

  task automatic check_addr(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      other_errors++;
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge CLOCK) begin
    if (arst_n) begin
      if (wb.en) begin
        check_wb(wb);
      end
      if (dmem_req.write) begin
        check_store(dmem_req);
      end
      if (imem_addr == END_PC) begin
        end_seen = 1'b1;
      end
    end
  end

  initial begin
    arst_n = 1'b0;
    void'($urandom(SEED));
    build_program();
    run_model();
    repeat (4) @(posedge CLOCK);
    arst_n <= 1'b1;
    @(negedge CLOCK);
    check_addr("reset fetch address", START_PC, imem_addr);
    if (wb.en || dmem_req.read || dmem_req.write) begin
      $display("ERROR: write-back or memory request active right after reset");
      other_errors++;
    end
    while (!(end_seen && exp_wb.size() == 0 && exp_store.size() == 0) && cycles < LIMIT) begin
      @(posedge CLOCK);
    end
    if (cycles >= LIMIT) begin
      $display("ERROR: run stopped at the limit of %0d cycles", LIMIT);
      other_errors++;
    end else begin
      repeat (10) @(posedge CLOCK);            // Catch stray events
    end
    if (exp_wb.size() != 0 || exp_store.size() != 0) begin
      $display("ERROR: %0d write-backs and %0d stores expected but never seen",
               exp_wb.size(), exp_store.size());
      other_errors++;
    end
    if (!end_seen) begin
      $display("ERROR: the closing branch was never fetched");
      other_errors++;
    end
    $display("Errors: write-back %0d, store %0d, other %0d, assertion %0d",
             wb_errors, store_errors, other_errors, u_dut.u_assertions.fail_count);
    if (wb_errors + store_errors + other_errors + u_dut.u_assertions.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/arm_core.sv
`default_nettype none

module arm_core #(
  parameter logic [arm_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                            CLOCK,
  input  wire logic                            arst_n,
  output logic [arm_pipe_pkg::XLEN-1:0]        imem_addr,
  input  wire logic [31:0]                     imem_data,
  output arm_pipe_pkg::dmem_req_t              dmem_req,
  input  wire logic [arm_pipe_pkg::XLEN-1:0]   dmem_rdata,
  output arm_pipe_pkg::wb_t                    wb
);
  import arm_pipe_pkg::*;

  logic [XLEN-1:0]  if_pc;
  instr_u           if_instr;
  logic [REG_W-1:0] rs1;
  logic [REG_W-1:0] rs2;
  logic [XLEN-1:0]  rs1_data;
  logic [XLEN-1:0]  rs2_data;
  logic             stall;
  redirect_t        redirect;
  id_ex_t           id_ex;
  ex_mem_t          ex_mem;
  fwd_sel_e         fwd_a;
  fwd_sel_e         fwd_b;

  arm_fetch #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .CLOCK(CLOCK), .arst_n(arst_n), .stall(stall), .redirect(redirect),
    .imem_data(imem_data), .imem_addr(imem_addr), .if_pc(if_pc), .if_instr(if_instr)
  );

  arm_decode u_decode (
    .CLOCK(CLOCK), .arst_n(arst_n), .if_pc(if_pc), .if_instr(if_instr),
    .stall(stall), .redirect(redirect), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1(rs1), .rs2(rs2), .id_ex(id_ex)
  );

  arm_regfile u_regfile (
    .CLOCK(CLOCK), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .wb(wb),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  arm_hazard_unit u_hazard (
    .rs1(rs1), .rs2(rs2), .id_ex(id_ex), .ex_mem(ex_mem),
    .mem_wb_rd(wb.rd), .mem_wb_en(wb.en),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  arm_execute u_execute (
    .CLOCK(CLOCK), .arst_n(arst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .wb_data(wb.data), .ex_mem(ex_mem), .redirect(redirect)
  );

  arm_mem_wb u_mem_wb (
    .CLOCK(CLOCK), .arst_n(arst_n), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata), .wb(wb)
  );

  // Data port straight from EX/MEM
  assign dmem_req = '{addr: ex_mem.alu_result, wdata: ex_mem.store_data,
                      read: ex_mem.ctrl.mem_read, write: ex_mem.ctrl.mem_write};

endmodule

`default_nettype wire

//--- verilog/arm_decode.sv
`default_nettype none

module arm_decode (
  input  wire logic                            CLOCK,
  input  wire logic                            arst_n,
  input  wire logic [arm_pipe_pkg::XLEN-1:0]   if_pc,
  input  wire arm_pipe_pkg::instr_u            if_instr,
  input  wire logic                            stall,
  input  wire arm_pipe_pkg::redirect_t         redirect,
  input  wire logic [arm_pipe_pkg::XLEN-1:0]   rs1_data,
  input  wire logic [arm_pipe_pkg::XLEN-1:0]   rs2_data,
  output logic [arm_pipe_pkg::REG_W-1:0]       rs1,
  output logic [arm_pipe_pkg::REG_W-1:0]       rs2,
  output arm_pipe_pkg::id_ex_t                 id_ex
);
  import arm_pipe_pkg::*;

  ctrl_t            dec_ctrl;
  logic [XLEN-1:0]  imm;
  logic [REG_W-1:0] rd;

  ctrl_t            ctrl_q;
  logic [XLEN-1:0]  pc_q;
  logic [XLEN-1:0]  rs1_data_q;
  logic [XLEN-1:0]  rs2_data_q;
  logic [XLEN-1:0]  imm_q;
  logic [REG_W-1:0] rn_q;
  logic [REG_W-1:0] rm_q;
  logic [REG_W-1:0] rd_q;

  assign rs1 = if_instr.r_fmt.rn;
  assign rs2 = if_instr[28] ? if_instr.d_fmt.rt : if_instr.r_fmt.rm;  // STUR, CBZ use rt
  assign rd  = if_instr.r_fmt.rd;

  always_comb begin
    dec_ctrl = '0;
    if (if_instr.b_fmt.opcode == OP_B) begin
      dec_ctrl.alu_op = ALU_PASS_B;
      dec_ctrl.is_b   = 1'b1;
    end else if (if_instr.cb_fmt.opcode == OP_CBZ) begin
      dec_ctrl.alu_op = ALU_PASS_B;     // Passes rt to the zero test
      dec_ctrl.is_cbz = 1'b1;
    end else begin
      case (if_instr.r_fmt.opcode)
        OP_LDUR: begin
          dec_ctrl.alu_op     = ALU_ADD;
          dec_ctrl.alu_src    = 1'b1;
          dec_ctrl.mem_read   = 1'b1;
          dec_ctrl.reg_write  = 1'b1;
          dec_ctrl.mem_to_reg = 1'b1;
        end
        OP_STUR: begin
          dec_ctrl.alu_op    = ALU_ADD;
          dec_ctrl.alu_src   = 1'b1;
          dec_ctrl.mem_write = 1'b1;
        end
        OP_ADD: begin
          dec_ctrl.alu_op    = ALU_ADD;
          dec_ctrl.reg_write = 1'b1;
        end
        OP_SUB: begin
          dec_ctrl.alu_op    = ALU_SUB;
          dec_ctrl.reg_write = 1'b1;
        end
        OP_AND: begin
          dec_ctrl.alu_op    = ALU_AND;
          dec_ctrl.reg_write = 1'b1;
        end
        OP_ORR: begin
          dec_ctrl.alu_op    = ALU_ORR;
          dec_ctrl.reg_write = 1'b1;
        end
        default: dec_ctrl = '0;         // Unknown opcode runs as NOP
      endcase
    end
    if (rd == ZERO_REG) begin
      dec_ctrl.reg_write = 1'b0;        // XZR is never written
    end
  end

  always_comb begin
    if (dec_ctrl.is_b) begin
      imm = {{(XLEN-26){if_instr.b_fmt.imm26[25]}}, if_instr.b_fmt.imm26};
    end else if (dec_ctrl.is_cbz) begin
      imm = {{(XLEN-19){if_instr.cb_fmt.imm19[18]}}, if_instr.cb_fmt.imm19};
    end else begin
      imm = {{(XLEN-9){if_instr.d_fmt.imm9[8]}}, if_instr.d_fmt.imm9};
    end
  end

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
    end else if (stall || redirect.taken) begin
      ctrl_q <= '0;                     // Bubble
    end else begin
      ctrl_q <= dec_ctrl;
    end
  end

  always_ff @(posedge CLOCK) begin
    pc_q       <= if_pc;
    rs1_data_q <= rs1_data;
    rs2_data_q <= rs2_data;
    imm_q      <= imm;
    rn_q       <= rs1;
    rm_q       <= rs2;
    rd_q       <= rd;
  end

  assign id_ex = '{ctrl: ctrl_q, pc: pc_q, rs1_data: rs1_data_q, rs2_data: rs2_data_q,
                   imm: imm_q, rn: rn_q, rm: rm_q, rd: rd_q};

endmodule

`default_nettype wire

//--- verilog/arm_execute.sv
`default_nettype none

module arm_execute (
  input  wire logic                            CLOCK,
  input  wire logic                            arst_n,
  input  wire arm_pipe_pkg::id_ex_t            id_ex,
  input  wire arm_pipe_pkg::fwd_sel_e          fwd_a,
  input  wire arm_pipe_pkg::fwd_sel_e          fwd_b,
  input  wire logic [arm_pipe_pkg::XLEN-1:0]   wb_data,
  output arm_pipe_pkg::ex_mem_t                ex_mem,
  output arm_pipe_pkg::redirect_t              redirect
);
  import arm_pipe_pkg::*;

  logic [XLEN-1:0]  op_a;
  logic [XLEN-1:0]  op_b;
  logic [XLEN-1:0]  alu_b;
  logic [XLEN-1:0]  alu_result;
  logic             branch_taken;

  ctrl_t            ctrl_q;
  logic [XLEN-1:0]  result_q;
  logic [XLEN-1:0]  store_q;
  logic [REG_W-1:0] rd_q;

  function automatic logic [XLEN-1:0] fwd_mux(
    input fwd_sel_e        sel,
    input logic [XLEN-1:0] reg_val,
    input logic [XLEN-1:0] mem_val,
    input logic [XLEN-1:0] wb_val
  );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, id_ex.rs1_data, result_q, wb_data);
  assign op_b  = fwd_mux(fwd_b, id_ex.rs2_data, result_q, wb_data);
  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;  // Address offset for LDUR, STUR

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_AND: alu_result = op_a & alu_b;
      ALU_ORR: alu_result = op_a | alu_b;
      ALU_ADD: alu_result = op_a + alu_b;
      ALU_SUB: alu_result = op_a - alu_b;
      default: alu_result = alu_b;       // PASS_B
    endcase
  end

  // CBZ tests the forwarded rt, B always goes
  assign branch_taken = id_ex.ctrl.is_b || (id_ex.ctrl.is_cbz && (alu_result == '0));

  assign redirect = '{taken: branch_taken, target: id_ex.pc + (id_ex.imm << 2)};

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= id_ex.ctrl;
    end
  end

  always_ff @(posedge CLOCK) begin
    result_q <= alu_result;
    store_q  <= op_b;                    // STUR data from rt
    rd_q     <= id_ex.rd;
  end

  assign ex_mem = '{ctrl: ctrl_q, alu_result: result_q, store_data: store_q, rd: rd_q};

endmodule

`default_nettype wire

//--- verilog/arm_fetch.sv
`default_nettype none

module arm_fetch #(
  parameter logic [arm_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                            CLOCK,
  input  wire logic                            arst_n,
  input  wire logic                            stall,
  input  wire arm_pipe_pkg::redirect_t         redirect,
  input  wire logic [31:0]                     imem_data,
  output logic [arm_pipe_pkg::XLEN-1:0]        imem_addr,
  output logic [arm_pipe_pkg::XLEN-1:0]        if_pc,
  output arm_pipe_pkg::instr_u                 if_instr
);
  import arm_pipe_pkg::*;

  logic [XLEN-1:0] pc_q;

  assign imem_addr = pc_q;

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect.taken) begin
      pc_q <= redirect.target;     // Branch resolved in EX
    end else if (!stall) begin
      pc_q <= pc_q + XLEN'(4);
    end
  end

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      if_instr <= '0;              // All-zero word decodes as NOP
      if_pc    <= '0;
    end else if (redirect.taken) begin
      if_instr <= '0;              // Kill the wrong-path fetch
    end else if (!stall) begin
      if_instr <= imem_data;
      if_pc    <= pc_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/arm_hazard_unit.sv
`default_nettype none

module arm_hazard_unit (
  input  wire logic [arm_pipe_pkg::REG_W-1:0]  rs1,
  input  wire logic [arm_pipe_pkg::REG_W-1:0]  rs2,
  input  wire arm_pipe_pkg::id_ex_t            id_ex,
  input  wire arm_pipe_pkg::ex_mem_t           ex_mem,
  input  wire logic [arm_pipe_pkg::REG_W-1:0]  mem_wb_rd,
  input  wire logic                            mem_wb_en,
  output logic                                 stall,
  output arm_pipe_pkg::fwd_sel_e               fwd_a,
  output arm_pipe_pkg::fwd_sel_e               fwd_b
);
  import arm_pipe_pkg::*;

  // Nearest producer wins
  function automatic fwd_sel_e pick_src(
    input logic [REG_W-1:0] src,
    input logic [REG_W-1:0] mem_rd,
    input logic             mem_en,
    input logic [REG_W-1:0] wb_rd,
    input logic             wb_en
  );
    if (mem_en && (mem_rd != ZERO_REG) && (mem_rd == src)) begin
      return FWD_MEM;
    end
    if (wb_en && (wb_rd != ZERO_REG) && (wb_rd == src)) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  // Load result is not ready until MEM/WB
  assign stall = id_ex.ctrl.mem_read && (id_ex.rd != ZERO_REG) &&
                 ((id_ex.rd == rs1) || (id_ex.rd == rs2));

  always_comb begin
    fwd_a = pick_src(id_ex.rn, ex_mem.rd, ex_mem.ctrl.reg_write, mem_wb_rd, mem_wb_en);
    fwd_b = pick_src(id_ex.rm, ex_mem.rd, ex_mem.ctrl.reg_write, mem_wb_rd, mem_wb_en);
  end

endmodule

`default_nettype wire

//--- verilog/arm_mem_wb.sv
`default_nettype none

module arm_mem_wb (
  input  wire logic                            CLOCK,
  input  wire logic                            arst_n,
  input  wire arm_pipe_pkg::ex_mem_t           ex_mem,
  input  wire logic [arm_pipe_pkg::XLEN-1:0]   dmem_rdata,
  output arm_pipe_pkg::wb_t                    wb
);
  import arm_pipe_pkg::*;

  logic             en_q;
  logic             mem_to_reg_q;
  logic [REG_W-1:0] rd_q;
  logic [XLEN-1:0]  alu_q;
  logic [XLEN-1:0]  load_q;

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      en_q         <= 1'b0;
      mem_to_reg_q <= 1'b0;
    end else begin
      en_q         <= ex_mem.ctrl.reg_write;
      mem_to_reg_q <= ex_mem.ctrl.mem_to_reg;
    end
  end

  always_ff @(posedge CLOCK) begin
    rd_q   <= ex_mem.rd;
    alu_q  <= ex_mem.alu_result;
    load_q <= dmem_rdata;              // Combinational read data
  end

  assign wb = '{en: en_q, rd: rd_q, data: mem_to_reg_q ? load_q : alu_q};

endmodule

`default_nettype wire

//--- verilog/arm_pipe_pkg.sv
`default_nettype none

package arm_pipe_pkg;

  localparam int XLEN  = 64;  // Data and address width
  localparam int REG_W = 5;   // Register index width

  localparam logic [REG_W-1:0] ZERO_REG = 5'd31;  // XZR

  // Bits 31:21 for the R and D formats
  localparam logic [10:0] OP_LDUR = 11'b11111000010;
  localparam logic [10:0] OP_STUR = 11'b11111000000;
  localparam logic [10:0] OP_ADD  = 11'b10001011000;
  localparam logic [10:0] OP_SUB  = 11'b11001011000;
  localparam logic [10:0] OP_AND  = 11'b10001010000;
  localparam logic [10:0] OP_ORR  = 11'b10101010000;
  localparam logic [7:0]  OP_CBZ  = 8'b10110100;   // Bits 31:24
  localparam logic [5:0]  OP_B    = 6'b000101;     // Bits 31:26

  typedef enum logic [3:0] {
    ALU_AND    = 4'b0000,
    ALU_ORR    = 4'b0001,
    ALU_ADD    = 4'b0010,
    ALU_SUB    = 4'b0110,
    ALU_PASS_B = 4'b0111  // Zero test for CBZ
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG = 2'b00,  // Value read in decode
    FWD_WB  = 2'b01,  // MEM/WB result
    FWD_MEM = 2'b10   // EX/MEM result
  } fwd_sel_e;

  typedef union packed {
    struct packed {
      logic [10:0]      opcode;
      logic [REG_W-1:0] rm;
      logic [5:0]       shamt;
      logic [REG_W-1:0] rn;
      logic [REG_W-1:0] rd;
    } r_fmt;
    struct packed {
      logic [10:0]      opcode;
      logic [8:0]       imm9;
      logic [1:0]       op2;
      logic [REG_W-1:0] rn;
      logic [REG_W-1:0] rt;
    } d_fmt;
    struct packed {
      logic [7:0]       opcode;
      logic [18:0]      imm19;
      logic [REG_W-1:0] rt;
    } cb_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] imm26;
    } b_fmt;
  } instr_u;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;     // Immediate as operand B
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    logic    is_cbz;
    logic    is_b;
  } ctrl_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    ctrl_t            ctrl;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    logic [XLEN-1:0]  imm;       // Sign extended, not yet scaled
    logic [REG_W-1:0] rn;
    logic [REG_W-1:0] rm;        // Second source, rm or rt
    logic [REG_W-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t            ctrl;
    logic [XLEN-1:0]  alu_result;
    logic [XLEN-1:0]  store_data;
    logic [REG_W-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            read;
    logic            write;
  } dmem_req_t;

  typedef struct packed {
    logic             en;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
  } wb_t;

endpackage

`default_nettype wire

//--- verilog/arm_regfile.sv
`default_nettype none

module arm_regfile (
  input  wire logic                            CLOCK,
  input  wire logic                            arst_n,
  input  wire logic [arm_pipe_pkg::REG_W-1:0]  rs1,
  input  wire logic [arm_pipe_pkg::REG_W-1:0]  rs2,
  input  wire arm_pipe_pkg::wb_t               wb,
  output logic [arm_pipe_pkg::XLEN-1:0]        rs1_data,
  output logic [arm_pipe_pkg::XLEN-1:0]        rs2_data
);
  import arm_pipe_pkg::*;

  logic [XLEN-1:0] regs [0:ZERO_REG-1];  // X0 to X30

  function automatic logic [XLEN-1:0] read_reg(input logic [REG_W-1:0] idx);
    if (idx == ZERO_REG) begin
      return '0;
    end
    if (wb.en && (wb.rd == idx)) begin
      return wb.data;                    // Write-through
    end
    return regs[idx];
  endfunction

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ZERO_REG; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.rd != ZERO_REG)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    rs1_data = read_reg(rs1);
    rs2_data = read_reg(rs2);
  end

endmodule

`default_nettype wire
